// ==== Bender.yml ====
package:
  name: issue_core

export_include_dirs:
  - design

sources:
  - design/rv_pkg.sv
  - design/instr_decoder.sv
  - design/register_file.sv
  - design/alu_pipe.sv
  - design/issue_core_top.sv
  - target: test
    files:
      - dv/clk_rst_gen.sv
      - dv/issue_core_tb.sv

// ==== design/alu_pipe.sv ====
`timescale 1ns/100ps

module alu_pipe
    import rv_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  accept_i,
    input  dec_t  dec_i,
    input  xlen_t rs1_data_i,
    input  xlen_t rs2_data_i,
    output wb_t   wb_o
);

    ex_t   ex_d;
    ex_t   ex_q;
    xlen_t alu_res;
    wb_t   wb_d;

    // ----------------------------------------------------------------------
    // Stage 1, operand latch
    // ----------------------------------------------------------------------
    always_comb begin
        ex_d.valid    = accept_i;
        ex_d.rd       = dec_i.rd;
        ex_d.write_rd = dec_i.write_rd;
        ex_d.op_a     = rs1_data_i;
        // Immediate replaces rs2 for OP-IMM and LUI
        ex_d.op_b     = dec_i.use_imm ? dec_i.imm : rs2_data_i;
        ex_d.alu_op   = dec_i.alu_op;
    end

    // Bubble when nothing accepted
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_d;
        end
    end

    // ----------------------------------------------------------------------
    // Stage 2, ALU and writeback register
    // ----------------------------------------------------------------------
    always_comb begin
        unique case (ex_q.alu_op)
            ALU_SUB:    alu_res = ex_q.op_a - ex_q.op_b;
            ALU_AND:    alu_res = ex_q.op_a & ex_q.op_b;
            ALU_OR:     alu_res = ex_q.op_a | ex_q.op_b;
            ALU_XOR:    alu_res = ex_q.op_a ^ ex_q.op_b;
            // Signed compare, result 0 or 1
            ALU_SLT:    alu_res = xlen_t'($signed(ex_q.op_a) < $signed(ex_q.op_b));
            ALU_PASS_B: alu_res = ex_q.op_b;
            default:    alu_res = ex_q.op_a + ex_q.op_b;
        endcase
    end

    // Writes to x0 retire silently
    assign wb_d.valid = ex_q.valid && ex_q.write_rd && (ex_q.rd != '0);
    assign wb_d.rd    = ex_q.rd;
    assign wb_d.data  = alu_res;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= wb_d;
        end
    end

    // ----------------------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------------------
    a_wb_rd_nonzero : assert property (@(posedge clk_i) disable iff (!rst_i)
        wb_o.valid |-> (wb_o.rd != '0));

    // Writing instruction retires exactly two edges after accept
    a_wb_latency : assert property (@(posedge clk_i) disable iff (!rst_i)
        (accept_i && dec_i.write_rd && dec_i.rd != '0)
            |-> ##2 (wb_o.valid && wb_o.rd == $past(dec_i.rd, 2)));

endmodule

// ==== design/instr_decoder.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module instr_decoder
    import rv_pkg::*;
(
    input  instr_t instr_i,
    output dec_t   dec_o
);

    // Major opcodes handled here
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i_type;
    xlen_t      imm_u_type;

    // ----------------------------------------------------------------------
    // Field extraction
    // ----------------------------------------------------------------------
    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // Sign-extended I immediate
    assign imm_i_type = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
    // U immediate, low 12 bits zero
    assign imm_u_type = {{(`RV_XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};

    // ----------------------------------------------------------------------
    // Opcode decode
    // ----------------------------------------------------------------------
    always_comb begin
        // Default is a bubble, register fields still extracted
        dec_o          = '0;
        dec_o.rs1      = instr_i[19:15];
        dec_o.rs2      = instr_i[24:20];
        dec_o.rd       = instr_i[11:7];
        dec_o.imm      = imm_i_type;
        dec_o.alu_op   = ALU_ADD;

        unique case (opcode)
            OPC_OP: begin
                // Register-register, only base funct7 plus SUB
                dec_o.read_rs1 = 1'b1;
                dec_o.read_rs2 = 1'b1;
                dec_o.write_rd = 1'b1;
                unique case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b010}: dec_o.alu_op = ALU_SLT;
                    {7'b0000000, 3'b100}: dec_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: dec_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: dec_o.alu_op = ALU_AND;
                    default: begin
                        dec_o.read_rs1 = 1'b0;
                        dec_o.read_rs2 = 1'b0;
                        dec_o.write_rd = 1'b0;
                    end
                endcase
            end
            OPC_OP_IMM: begin
                // Register-immediate, slti and shifts become bubbles
                dec_o.read_rs1 = 1'b1;
                dec_o.write_rd = 1'b1;
                dec_o.use_imm  = 1'b1;
                unique case (funct3)
                    3'b000: dec_o.alu_op = ALU_ADD;
                    3'b100: dec_o.alu_op = ALU_XOR;
                    3'b110: dec_o.alu_op = ALU_OR;
                    3'b111: dec_o.alu_op = ALU_AND;
                    default: begin
                        dec_o.read_rs1 = 1'b0;
                        dec_o.write_rd = 1'b0;
                        dec_o.use_imm  = 1'b0;
                    end
                endcase
            end
            OPC_LUI: begin
                // No sources, immediate passes through
                dec_o.write_rd = 1'b1;
                dec_o.use_imm  = 1'b1;
                dec_o.imm      = imm_u_type;
                dec_o.alu_op   = ALU_PASS_B;
            end
            default: begin
                // Anything else issues as a bubble
                dec_o.alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

// ==== design/issue_core_top.sv ====
`timescale 1ns/100ps

module issue_core_top
    import rv_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   instr_valid_i,
    input  instr_t instr_i,
    output logic   stall_o,
    output wb_t    wb_o
);

    dec_t  dec;
    xlen_t rs1_data;
    xlen_t rs2_data;
    logic  stall;
    logic  accept;

    // ----------------------------------------------------------------------
    // Decode
    // ----------------------------------------------------------------------
    instr_decoder u_instr_decoder (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    // ----------------------------------------------------------------------
    // Operand read and scoreboard
    // ----------------------------------------------------------------------
    register_file u_register_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (instr_valid_i),
        .dec_i      (dec),
        .wb_i       (wb_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .stall_o    (stall)
    );

    // Issue when valid and no hazard
    assign accept  = instr_valid_i && !stall;
    assign stall_o = stall;

    // ----------------------------------------------------------------------
    // Execute and writeback
    // ----------------------------------------------------------------------
    alu_pipe u_alu_pipe (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .accept_i   (accept),
        .dec_i      (dec),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .wb_o       (wb_o)
    );

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module register_file
    import rv_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  valid_i,
    input  dec_t  dec_i,
    input  wb_t   wb_i,
    output xlen_t rs1_data_o,
    output xlen_t rs2_data_o,
    output logic  stall_o
);

    // Architectural state and per-register scoreboard
    xlen_t regs_q [`RV_NREGS];
    pend_t pend_q [`RV_NREGS];

    logic rs1_ready;
    logic rs2_ready;
    logic rd_full;
    logic accept;
    logic cnt_inc;
    logic cnt_dec;
    logic same_rd;

    // ----------------------------------------------------------------------
    // Read ports and hazard detection
    // ----------------------------------------------------------------------

    // Source ready once no write is pending
    assign rs1_ready = (pend_q[dec_i.rs1] == '0);
    assign rs2_ready = (pend_q[dec_i.rs2] == '0);

    // Saturated destination counter, x0 never counts
    assign rd_full = dec_i.write_rd && (dec_i.rd != '0) && (pend_q[dec_i.rd] == '1);

    // Data gated to zero while a source is unused or not ready
    assign rs1_data_o = (dec_i.read_rs1 && rs1_ready) ? regs_q[dec_i.rs1] : '0;
    assign rs2_data_o = (dec_i.read_rs2 && rs2_ready) ? regs_q[dec_i.rs2] : '0;

    assign stall_o = valid_i && ((dec_i.read_rs1 && !rs1_ready) ||
                                 (dec_i.read_rs2 && !rs2_ready) ||
                                 rd_full);

    // Same accept condition the top hands to the execute pipe
    assign accept = valid_i && !stall_o;

    // ----------------------------------------------------------------------
    // Scoreboard update and write port
    // ----------------------------------------------------------------------
    assign cnt_inc = accept && dec_i.write_rd && (dec_i.rd != '0);
    assign cnt_dec = wb_i.valid && (wb_i.rd != '0);
    // Issue and retire on one register cancel out
    assign same_rd = cnt_inc && cnt_dec && (wb_i.rd == dec_i.rd);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs_q[i] <= '0;
                pend_q[i] <= '0;
            end
        end else begin
            if (cnt_inc && !same_rd) begin
                pend_q[dec_i.rd] <= pend_q[dec_i.rd] + pend_t'(1);
            end
            if (cnt_dec && !same_rd) begin
                pend_q[wb_i.rd] <= pend_q[wb_i.rd] - pend_t'(1);
            end
            // Writeback data lands even when the counter holds
            if (cnt_dec) begin
                regs_q[wb_i.rd] <= wb_i.data;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------------------

    // Every retiring write was counted at issue
    a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_i)
        cnt_dec |-> (pend_q[wb_i.rd] != '0));

    // Counted register keeps its pending mark until retire
    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_i)
        (cnt_inc && !same_rd) |=> (pend_q[$past(dec_i.rd)] != '0));

    // x0 stays hardwired zero
    a_x0_zero : assert property (@(posedge clk_i) disable iff (!rst_i)
        (dec_i.read_rs1 && dec_i.rs1 == '0) |-> (rs1_data_o == '0));

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

    `include "rv_settings.svh"

    // Plain vector types
    typedef logic [`RV_XLEN-1:0]           xlen_t;
    typedef logic [$clog2(`RV_NREGS)-1:0]  reg_idx_t;
    typedef logic [31:0]                   instr_t;
    typedef logic [`RV_PEND_W-1:0]         pend_t;

    // ALU operations, PASS_B serves LUI
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // Decoder output
    typedef struct packed {
        logic     read_rs1;
        logic     read_rs2;
        logic     write_rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     use_imm;
        xlen_t    imm;
        alu_op_e  alu_op;
    } dec_t;

    // Operand latch between issue and ALU
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     write_rd;
        xlen_t    op_a;
        xlen_t    op_b;
        alu_op_e  alu_op;
    } ex_t;

    // Writeback bus back to the register file
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

endpackage

// ==== design/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// ----------------------------------------------------------------------
// Core sizing
// ----------------------------------------------------------------------

// Data path width
`define RV_XLEN 32

// Architectural registers x0..x31
`define RV_NREGS 32

// ----------------------------------------------------------------------
// Scoreboard sizing
// ----------------------------------------------------------------------

// Pending-write counter, saturates at 3 writes in flight
`define RV_PEND_W 2

`endif

// ==== dv/clk_rst_gen.sv ====
`timescale 1ns/100ps

module clk_rst_gen (
    output logic clk_o,
    output logic rst_o
);

    // 20 ns period
    localparam int HALF_PERIOD = 10;
    localparam int RST_CYCLES  = 5;

    // Free-running clock
    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

    // Active-low reset, released on a rising edge
    initial begin
        rst_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

// ==== dv/issue_core_tb.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module issue_core_tb
    import rv_pkg::*;
();

    // One program step with its word, idle cycles after accept and expected stall
    typedef struct packed {
        instr_t word;
        int     gap;
        logic   expect_stall;
    } entry_t;

    localparam int STALL_LIMIT = 32;
    localparam int DRAIN_LIMIT = 64;
    localparam int RST_LIMIT   = 20;
    localparam int N_RANDOM    = 16;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    instr_t      instr;
    logic        stall;
    wb_t         wb;
    entry_t      prog [$];
    wb_t         exp_wb [$];
    wb_t         want;
    xlen_t       model [`RV_NREGS];
    logic [31:0] rng_state;
    int          data_errs;
    int          stall_errs;
    int          timeouts;

    clk_rst_gen u_clk_rst_gen (
        .clk_o (clk),
        .rst_o (rst_n)
    );

    issue_core_top dut (
        .clk_i         (clk),
        .rst_i         (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .stall_o       (stall),
        .wb_o          (wb)
    );

    // ----------------------------------------------------------------------
    // Encoders and random source
    // ----------------------------------------------------------------------
    function automatic instr_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t enc_i(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                     logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic instr_t enc_lui(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ----------------------------------------------------------------------
    // Architectural reference model
    // ----------------------------------------------------------------------
    function automatic void ref_exec(input instr_t w, output logic wr, output xlen_t res);
        xlen_t a;
        xlen_t b;
        xlen_t imm;
        a   = model[w[19:15]];
        b   = model[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        wr  = 1'b1;
        res = '0;
        case (w[6:0])
            7'b0110011: begin
                case ({w[31:25], w[14:12]})
                    10'b0000000_000: res = a + b;
                    10'b0100000_000: res = a - b;
                    // With differing signs the negative one is less
                    10'b0000000_010: res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
                    10'b0000000_100: res = a ^ b;
                    10'b0000000_110: res = a | b;
                    10'b0000000_111: res = a & b;
                    default:         wr  = 1'b0;
                endcase
            end
            7'b0010011: begin
                case (w[14:12])
                    3'b000:  res = a + imm;
                    3'b100:  res = a ^ imm;
                    3'b110:  res = a | imm;
                    3'b111:  res = a & imm;
                    default: wr  = 1'b0;
                endcase
            end
            7'b0110111: res = {w[31:12], 12'b0};
            default:    wr  = 1'b0;
        endcase
    endfunction

    task automatic put(input instr_t w, input int gap, input logic st);
        entry_t e;
        e.word         = w;
        e.gap          = gap;
        e.expect_stall = st;
        prog.push_back(e);
    endtask

    // ----------------------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------------------
    task automatic build_table();
        logic [31:0] r;
        reg_idx_t    rd;
        instr_t      w;
        // Independent writes from x0 with a final write to x0
        put(enc_lui(5'd1, 20'h12345), 0, 1'b0);
        put(enc_i(3'd0, 5'd2, 5'd0, 12'h7ff), 0, 1'b0);
        put(enc_i(3'd0, 5'd3, 5'd0, 12'hffb), 0, 1'b0);
        put(enc_lui(5'd4, 20'h80000), 0, 1'b0);
        put(enc_i(3'd4, 5'd5, 5'd0, 12'h5a5), 0, 1'b0);
        put(enc_lui(5'd0, 20'habcde), 2, 1'b0);
        // Every ALU op on settled sources
        put(enc_r(7'h00, 3'd0, 5'd6, 5'd1, 5'd2), 0, 1'b0);
        put(enc_r(7'h20, 3'd0, 5'd7, 5'd3, 5'd4), 0, 1'b0);
        put(enc_r(7'h00, 3'd7, 5'd8, 5'd1, 5'd3), 0, 1'b0);
        put(enc_r(7'h00, 3'd6, 5'd9, 5'd2, 5'd4), 0, 1'b0);
        put(enc_r(7'h00, 3'd4, 5'd10, 5'd5, 5'd1), 0, 1'b0);
        put(enc_r(7'h00, 3'd2, 5'd11, 5'd3, 5'd2), 0, 1'b0);
        put(enc_r(7'h00, 3'd2, 5'd12, 5'd2, 5'd3), 0, 1'b0);
        put(enc_i(3'd7, 5'd13, 5'd3, 12'h0f0), 0, 1'b0);
        put(enc_i(3'd6, 5'd14, 5'd4, 12'h123), 0, 1'b0);
        put(enc_r(7'h00, 3'd0, 5'd0, 5'd1, 5'd2), 2, 1'b0);
        // RAW chain where each reads the one before
        put(enc_i(3'd0, 5'd15, 5'd0, 12'd100), 0, 1'b0);
        put(enc_i(3'd0, 5'd16, 5'd15, 12'd23), 0, 1'b1);
        put(enc_r(7'h20, 3'd0, 5'd17, 5'd16, 5'd15), 0, 1'b1);
        put(enc_r(7'h00, 3'd2, 5'd18, 5'd17, 5'd16), 2, 1'b1);
        // WAW on x19 peaks at two pending writes with back-to-back issue
        put(enc_i(3'd0, 5'd19, 5'd0, 12'd1), 0, 1'b0);
        put(enc_i(3'd0, 5'd19, 5'd0, 12'd2), 0, 1'b0);
        put(enc_i(3'd0, 5'd19, 5'd0, 12'd3), 0, 1'b0);
        put(enc_i(3'd0, 5'd19, 5'd0, 12'd4), 2, 1'b0);
        // Bubbles naming a pending x20
        put(enc_i(3'd0, 5'd20, 5'd0, 12'd7), 0, 1'b0);
        put({7'd0, 5'd20, 5'd20, 3'b010, 5'd0, 7'b0100011}, 0, 1'b0);
        put({7'd0, 5'd20, 5'd20, 3'b000, 5'd0, 7'b1100011}, 0, 1'b0);
        put(enc_i(3'd1, 5'd20, 5'd20, 12'h001), 0, 1'b0);
        put(enc_r(7'h01, 3'd0, 5'd21, 5'd20, 5'd20), 0, 1'b0);
        put(enc_i(3'd2, 5'd21, 5'd20, 12'h005), 0, 1'b0);
        put(32'h0000_0000, 2, 1'b0);
        // Random ops with gaps of two or more so sources settle
        for (int i = 0; i < N_RANDOM; i++) begin
            rng_state = xorshift(rng_state);
            r  = rng_state;
            rd = (r[4:0] == 5'd0) ? 5'd31 : r[4:0];
            case (r[24:22])
                3'd0:    w = enc_i(3'd0, rd, r[9:5], r[21:10]);
                3'd1:    w = enc_i(3'd4, rd, r[9:5], r[21:10]);
                3'd2:    w = enc_i(3'd6, rd, r[9:5], r[21:10]);
                3'd3:    w = enc_i(3'd7, rd, r[9:5], r[21:10]);
                3'd4:    w = enc_lui(rd, r[31:12]);
                3'd5:    w = enc_r(7'h00, 3'd0, rd, r[9:5], r[31:27]);
                3'd6:    w = enc_r(7'h20, 3'd0, rd, r[9:5], r[31:27]);
                default: w = enc_r(7'h00, 3'd2, rd, r[9:5], r[31:27]);
            endcase
            put(w, 2 + int'(r[26:25]), 1'b0);
        end
        // Readback of every register through ori rX, rX, 0
        for (int x = 0; x < `RV_NREGS; x++) begin
            put(enc_i(3'd6, reg_idx_t'(x), reg_idx_t'(x), 12'h000), 0, 1'b0);
        end
    endtask

    // ----------------------------------------------------------------------
    // Driver, monitor, end of run
    // ----------------------------------------------------------------------
    task automatic finish_run();
        $display("Errors: data %0d, stall %0d, timeout %0d", data_errs, stall_errs, timeouts);
        if (data_errs + stall_errs + timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic issue(input entry_t e);
        int    n;
        logic  saw_stall;
        logic  wr;
        xlen_t res;
        wb_t   w;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= e.word;
        // Model advances in program order
        ref_exec(e.word, wr, res);
        if (wr && e.word[11:7] != 5'd0) begin
            model[e.word[11:7]] = res;
            w.valid = 1'b1;
            w.rd    = e.word[11:7];
            w.data  = res;
            exp_wb.push_back(w);
        end
        saw_stall = 1'b0;
        n = 0;
        @(negedge clk);
        while (stall && n < STALL_LIMIT) begin
            saw_stall = 1'b1;
            n++;
            @(negedge clk);
        end
        if (stall) begin
            $display("Timeout: stall_o stayed high for instruction 0x%08h", e.word);
            timeouts++;
            finish_run();
        end
        if (saw_stall != e.expect_stall) begin
            $display("[ERROR] stall_o: got 0x%0h expected 0x%0h before accept of 0x%08h",
                     saw_stall, e.expect_stall, e.word);
            stall_errs++;
        end
        // Idle cycles after the accepting edge
        repeat (e.gap) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    // Writebacks checked in order at mid-cycle
    always @(negedge clk) begin
        if (rst_n && wb.valid) begin
            if (exp_wb.size() == 0) begin
                $display("Unexpected writeback to x%0d with nothing outstanding", wb.rd);
                data_errs++;
            end else begin
                want = exp_wb.pop_front();
                if (wb.rd != want.rd) begin
                    $display("[ERROR] wb_o.rd: got 0x%02h expected 0x%02h", wb.rd, want.rd);
                    data_errs++;
                end
                if (wb.data != want.data) begin
                    $display("[ERROR] wb_o.data: got 0x%08h expected 0x%08h (x%0d)",
                             wb.data, want.data, want.rd);
                    data_errs++;
                end
            end
        end
    end

    initial begin
        int n;
        rng_state  = 32'd33;
        data_errs  = 0;
        stall_errs = 0;
        timeouts   = 0;
        instr_valid <= 1'b0;
        instr       <= '0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            model[i] = '0;
        end
        build_table();
        n = 0;
        // Reset may still be unknown at time zero
        while (rst_n !== 1'b1 && n < RST_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timeouts++;
            finish_run();
        end
        foreach (prog[i]) begin
            issue(prog[i]);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        // Drain outstanding writebacks
        n = 0;
        while (exp_wb.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_wb.size() != 0) begin
            $display("Timeout: %0d expected writebacks never arrived", exp_wb.size());
            timeouts++;
        end
        // Room for any stray pulse
        repeat (4) @(posedge clk);
        finish_run();
    end

endmodule

// ==== vlog.f ====
+incdir+design
design/rv_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/alu_pipe.sv
design/issue_core_top.sv
dv/clk_rst_gen.sv
dv/issue_core_tb.sv
